//--- ahb_default_slave.sv
`timescale 1ns/1ps

module ahb_default_slave (
    input  logic             hclk,
    input  logic             hrstn,
    input  logic             hsel,
    input  ahb_pkg::htrans_t htrans,
    input  logic             hready_in,
    output logic             hreadyout,
    output logic             hresp,
    output ahb_pkg::hdata_t  hrdata
);
    import ahb_pkg::*;

    typedef enum logic {
        ok,    // Idle or ERROR tail cycle
        err1   // First ERROR cycle, stalls the bus
    } state_t;

    state_t state;
    logic   resp_q;   // ERROR flag, spans both error cycles
    logic   accept;

    assign accept = hsel && hready_in && (htrans == trans_nonseq || htrans == trans_seq);

    always_ff @(posedge hclk or negedge hrstn) begin
        if (!hrstn) begin
            state  <= ok;
            resp_q <= 1'b0;
        end else begin
            case (state)
                ok: begin
                    if (accept) begin
                        state  <= err1;
                        resp_q <= 1'b1;
                    end else begin
                        resp_q <= 1'b0;  // Tail over, back to OKAY
                    end
                end
                err1: state <= ok;  // resp_q held for the second cycle
            endcase
        end
    end

    assign hreadyout = (state != err1);
    assign hresp     = resp_q;
    assign hrdata    = '0;  // Nothing to read here

endmodule

//--- ahb_dsram_sys.sv
`timescale 1ns/1ps

module ahb_dsram_sys #(
    parameter int sram0_depth = 1024,  // Words in region 0
    parameter int sram1_depth = 256    // Words in region 1
) (
    input  logic             hclk,
    input  logic             hrstn,
    input  ahb_pkg::haddr_t  haddr,
    input  logic             hmastlock,  // Single master, unused
    input  logic [6:0]       hprot,      // No protection checks, unused
    input  ahb_pkg::hsize_t  hsize,
    input  ahb_pkg::htrans_t htrans,
    input  ahb_pkg::hdata_t  hwdata,
    input  logic             hwrite,
    output logic             hready,
    output logic             hresp,
    output ahb_pkg::hdata_t  hrdata
);
    import ahb_pkg::*;

    logic   hsel_sram0;
    logic   hsel_sram1;
    logic   hsel_default;
    hdata_t hrdata_sram0;
    hdata_t hrdata_sram1;
    hdata_t hrdata_default;
    logic   hreadyout_sram0;
    logic   hreadyout_sram1;
    logic   hreadyout_default;
    logic   hresp_sram0;
    logic   hresp_sram1;
    logic   hresp_default;

    // Decode and response mux
    ahb_interconnect #(
        .sram0_depth (sram0_depth),
        .sram1_depth (sram1_depth)
    ) ic_u (
        .hclk              (hclk),
        .hrstn             (hrstn),
        .haddr             (haddr),
        .htrans            (htrans),
        .hrdata_sram0      (hrdata_sram0),
        .hreadyout_sram0   (hreadyout_sram0),
        .hresp_sram0       (hresp_sram0),
        .hrdata_sram1      (hrdata_sram1),
        .hreadyout_sram1   (hreadyout_sram1),
        .hresp_sram1       (hresp_sram1),
        .hrdata_default    (hrdata_default),
        .hreadyout_default (hreadyout_default),
        .hresp_default     (hresp_default),
        .hsel_sram0        (hsel_sram0),
        .hsel_sram1        (hsel_sram1),
        .hsel_default      (hsel_default),
        .hrdata            (hrdata),
        .hready            (hready),
        .hresp             (hresp)
    );

    ahbs_dsram #(.depth(sram0_depth)) sram0_u (
        .hclk      (hclk),
        .hrstn     (hrstn),
        .hsel      (hsel_sram0),
        .haddr     (haddr),
        .htrans    (htrans),
        .hsize     (hsize),
        .hwrite    (hwrite),
        .hwdata    (hwdata),
        .hready_in (hready),        // Muxed ready back to every slave
        .hrdata    (hrdata_sram0),
        .hreadyout (hreadyout_sram0),
        .hresp     (hresp_sram0)
    );

    ahbs_dsram #(.depth(sram1_depth)) sram1_u (
        .hclk      (hclk),
        .hrstn     (hrstn),
        .hsel      (hsel_sram1),
        .haddr     (haddr),
        .htrans    (htrans),
        .hsize     (hsize),
        .hwrite    (hwrite),
        .hwdata    (hwdata),
        .hready_in (hready),
        .hrdata    (hrdata_sram1),
        .hreadyout (hreadyout_sram1),
        .hresp     (hresp_sram1)
    );

    // Catches everything outside the two SRAMs
    ahb_default_slave dflt_u (
        .hclk      (hclk),
        .hrstn     (hrstn),
        .hsel      (hsel_default),
        .htrans    (htrans),
        .hready_in (hready),
        .hreadyout (hreadyout_default),
        .hresp     (hresp_default),
        .hrdata    (hrdata_default)
    );

endmodule

//--- ahb_interconnect.sv
`timescale 1ns/1ps

module ahb_interconnect #(
    parameter int sram0_depth = 1024,
    parameter int sram1_depth = 256
) (
    input  logic             hclk,
    input  logic             hrstn,
    input  ahb_pkg::haddr_t  haddr,
    input  ahb_pkg::htrans_t htrans,
    input  ahb_pkg::hdata_t  hrdata_sram0,
    input  logic             hreadyout_sram0,
    input  logic             hresp_sram0,
    input  ahb_pkg::hdata_t  hrdata_sram1,
    input  logic             hreadyout_sram1,
    input  logic             hresp_sram1,
    input  ahb_pkg::hdata_t  hrdata_default,
    input  logic             hreadyout_default,
    input  logic             hresp_default,
    output logic             hsel_sram0,
    output logic             hsel_sram1,
    output logic             hsel_default,
    output ahb_pkg::hdata_t  hrdata,
    output logic             hready,
    output logic             hresp
);
    import ahb_pkg::*;
    import mem_pkg::*;

    localparam haddr_t span_bytes  = haddr_t'(region_span);
    localparam haddr_t sram0_limit = haddr_t'(sram0_depth * 4);  // Bytes actually backed
    localparam haddr_t sram1_limit = haddr_t'(sram1_depth * 4);

    haddr_t     off0;       // Offset into each region
    haddr_t     off1;
    logic       hit0;
    logic       hit1;
    logic       active;     // nonseq or seq
    slave_sel_t dec_sel;    // Address phase owner
    slave_sel_t dp_sel_q;   // Data phase owner
    logic       dp_pend_q;  // Active transfer in data phase

    assign off0   = haddr - sram0_base;
    assign off1   = haddr - sram1_base;
    assign hit0   = (off0 < span_bytes) && (off0 < sram0_limit);  // Region and depth check
    assign hit1   = (off1 < span_bytes) && (off1 < sram1_limit);
    assign active = (htrans == trans_nonseq) || (htrans == trans_seq);

    always_comb begin
        if (hit0) begin
            dec_sel = sel_sram0;
        end else if (hit1) begin
            dec_sel = sel_sram1;
        end else begin
            dec_sel = sel_default;  // Holes and beyond-depth words
        end
    end

    assign hsel_sram0   = (dec_sel == sel_sram0);
    assign hsel_sram1   = (dec_sel == sel_sram1);
    assign hsel_default = (dec_sel == sel_default);

    // Owner advances only when the bus accepts an address phase
    always_ff @(posedge hclk or negedge hrstn) begin
        if (!hrstn) begin
            dp_sel_q  <= sel_default;
            dp_pend_q <= 1'b0;
        end else if (hready) begin
            dp_sel_q  <= dec_sel;
            dp_pend_q <= active;
        end
    end

    // Response mux
    always_comb begin
        hrdata = '0;    // Idle data phase
        hready = 1'b1;
        hresp  = 1'b0;
        if (dp_pend_q) begin
            case (dp_sel_q)
                sel_sram0: begin
                    hrdata = hrdata_sram0;
                    hready = hreadyout_sram0;
                    hresp  = hresp_sram0;
                end
                sel_sram1: begin
                    hrdata = hrdata_sram1;
                    hready = hreadyout_sram1;
                    hresp  = hresp_sram1;
                end
                default: begin
                    hrdata = hrdata_default;
                    hready = hreadyout_default;
                    hresp  = hresp_default;
                end
            endcase
        end
    end

endmodule

//--- ahb_pkg.sv
package ahb_pkg;

    // Bus-side vector types
    typedef logic [31:0] haddr_t;   // Byte address
    typedef logic [31:0] hdata_t;   // Read and write data word
    typedef logic [1:0]  htrans_t;  // Transfer type
    typedef logic [2:0]  hsize_t;   // Transfer size

    // htrans codes
    localparam htrans_t trans_idle   = 2'b00;  // No transfer wanted
    localparam htrans_t trans_busy   = 2'b01;  // Master stalling a burst
    localparam htrans_t trans_nonseq = 2'b10;  // First or single transfer
    localparam htrans_t trans_seq    = 2'b11;  // Burst continuation

    // hsize codes, widths above a word not supported
    localparam hsize_t size_byte = 3'b000;  // 8 bit
    localparam hsize_t size_half = 3'b001;  // 16 bit
    localparam hsize_t size_word = 3'b010;  // 32 bit

    // Byte lanes per data word
    localparam int lanes = $bits(hdata_t) / 8;

endpackage

//--- ahbs_dsram.sv
`timescale 1ns/1ps

module ahbs_dsram #(
    parameter int depth = 1024  // Words
) (
    input  logic             hclk,
    input  logic             hrstn,
    input  logic             hsel,
    input  ahb_pkg::haddr_t  haddr,
    input  ahb_pkg::htrans_t htrans,
    input  ahb_pkg::hsize_t  hsize,
    input  logic             hwrite,
    input  ahb_pkg::hdata_t  hwdata,
    input  logic             hready_in,
    output ahb_pkg::hdata_t  hrdata,
    output logic             hreadyout,
    output logic             hresp
);
    import ahb_pkg::*;
    import mem_pkg::*;

    localparam int aw = $clog2(depth);  // Array index width

    hdata_t           mem_array [depth];  // Word storage
    logic             accept;             // Active address phase for this slave
    word_idx_t        addr_idx;           // Word index of the address phase
    logic [lanes-1:0] lane_mask;          // Lanes touched by the address phase
    logic             wr_pend;            // Write data phase in progress
    word_idx_t        wr_idx;
    logic [lanes-1:0] wr_mask;
    hdata_t           rd_word;            // Raw array word
    hdata_t           rd_merged;          // Array word plus forwarded lanes

    // Accept only nonseq and seq, idle and busy fall through as OKAY
    assign accept   = hsel && hready_in && (htrans == trans_nonseq || htrans == trans_seq);
    assign addr_idx = haddr[word_idx_w+1:2];

    // Lane decode, little endian
    always_comb begin
        case (hsize)
            size_byte: lane_mask = 4'b0001 << haddr[1:0];
            size_half: lane_mask = haddr[1] ? 4'b1100 : 4'b0011;  // Halfword aligned
            default:   lane_mask = 4'b1111;                        // Word
        endcase
    end

    assign rd_word = mem_array[addr_idx[aw-1:0]];

    // Write in its data phase lands on the same edge as this read samples
    // the array, so its lanes are taken straight from hwdata
    always_comb begin
        rd_merged = rd_word;
        for (int i = 0; i < lanes; i++) begin
            if (wr_pend && wr_idx == addr_idx && wr_mask[i]) begin
                rd_merged[8*i +: 8] = hwdata[8*i +: 8];  // Forward pending lane
            end
        end
    end

    // Control state and read data
    always_ff @(posedge hclk or negedge hrstn) begin
        if (!hrstn) begin
            wr_pend <= 1'b0;
            hrdata  <= '0;
        end else begin
            wr_pend <= accept && hwrite;                      // One-cycle data phase
            hrdata  <= (accept && !hwrite) ? rd_merged : '0;  // Zero outside read data phase
        end
    end

    // Write phase capture
    always_ff @(posedge hclk) begin
        if (accept && hwrite) begin
            wr_idx  <= addr_idx;
            wr_mask <= lane_mask;
        end
    end

    // Commit at the edge ending the write data phase
    always_ff @(posedge hclk) begin
        if (wr_pend) begin
            for (int i = 0; i < lanes; i++) begin
                if (wr_mask[i]) begin
                    mem_array[wr_idx[aw-1:0]][8*i +: 8] <= hwdata[8*i +: 8];
                end
            end
        end
    end

    assign hreadyout = 1'b1;  // Zero wait states
    assign hresp     = 1'b0;  // Always OKAY

endmodule

//--- filelist.f
ahb_pkg.sv
mem_pkg.sv
ahbs_dsram.sv
ahb_default_slave.sv
ahb_interconnect.sv
ahb_dsram_sys.sv
tb_ahb_dsram_sys.sv

//--- mem_pkg.sv
package mem_pkg;

    // Owner of the current data phase
    typedef enum logic [1:0] {
        sel_sram0   = 2'd0,
        sel_sram1   = 2'd1,
        sel_default = 2'd2   // Unmapped space
    } slave_sel_t;

    // Region map
    localparam ahb_pkg::haddr_t sram0_base = 32'h0000_0000;
    localparam ahb_pkg::haddr_t sram1_base = 32'h0001_0000;
    localparam int unsigned     region_span = 32'h0001_0000;  // 64 KB per region

    // Word index within one region
    localparam int word_idx_w = $clog2(region_span / 4);  // 14 bits for 64 KB
    typedef logic [word_idx_w-1:0] word_idx_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the AHB SRAM testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module tb_ahb_dsram_sys \
    -f filelist.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
run_status=$?
cat "$log"

if [ $run_status -eq 0 ] && grep -qx "all tests passed" "$log"; then
    echo "Simulation PASS"
    exit 0
fi
echo "Simulation FAIL (exit status $run_status)"
exit 1

//--- tb_ahb_dsram_sys.sv
`timescale 1ns/1ps

module tb_ahb_dsram_sys;
    import ahb_pkg::*;
    import mem_pkg::*;

    localparam int unsigned sram0_words = 1024;  // dut0 runs with default depths
    localparam int unsigned sram1_words = 256;
    localparam int          cycle_limit = 3000;  // Tests need about 300 cycles

    typedef enum logic [1:0] {dp_none, dp_okay, dp_error} dp_kind_t;

    logic       hclk = 1'b0;
    logic       hrstn;
    haddr_t     haddr;
    logic       hmastlock;
    logic [6:0] hprot;
    hsize_t     hsize;
    htrans_t    htrans;
    hdata_t     hwdata;
    logic       hwrite;
    logic       hready;
    logic       hresp;
    hdata_t     hrdata;

    hdata_t     ref_mem [haddr_t];  // Reference model keyed by word address
    dp_kind_t   pend_kind;          // Expected response of the current data phase
    logic       pend_write;
    haddr_t     pend_addr;
    hsize_t     pend_size;
    hdata_t     pend_wdata;         // Driven on hwdata in the data phase
    logic       pend_stalled;       // First ERROR cycle already seen
    int         cycles = 0;
    haddr_t     addr_list [32];
    // Unmapped addresses and the SRAM word each would hit if decode wrapped
    haddr_t     bad_addr [5] = '{32'h0000_1000, 32'h0000_fffc, 32'h0001_0400,
                                 32'h0002_0000, 32'hffff_fff0};
    haddr_t     alias_addr [5] = '{32'h0000_0000, 32'h0000_0ffc, 32'h0001_0000,
                                   32'h0000_0000, 32'h0000_0ff0};

    ahb_dsram_sys dut0 (.*);

    always #5 hclk = ~hclk;

    // Hang guard
    always @(posedge hclk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d clock cycles without reaching the end", cycle_limit);
            $display("tests failed");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    task automatic fail_now(input string msg);
        $display("FAIL at %0d ns: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "First mismatch ends the run");
    endtask

    function automatic haddr_t word_key(input haddr_t a);
        return {a[31:2], 2'b00};
    endfunction

    // Little endian lanes of an aligned transfer of 2**size bytes
    function automatic logic [3:0] lane_mask_of(input haddr_t a, input hsize_t s);
        int         nbytes;
        int         first;
        logic [3:0] m;
        nbytes = 1 << s;                        // Bytes in the transfer
        first  = int'(a[1:0]) & ~(nbytes - 1);  // Lowest lane, aligned to size
        m      = '0;
        for (int i = 0; i < 4; i++) begin
            m[i] = (i >= first) && (i < first + nbytes);
        end
        return m;
    endfunction

    function automatic hdata_t merge_lanes(input hdata_t old_w, input hdata_t new_w,
                                           input logic [3:0] mask);
        hdata_t r;
        r = old_w;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) r[8*i +: 8] = new_w[8*i +: 8];  // Only touched lanes
        end
        return r;
    endfunction

    // Backed words only, holes and beyond-depth space are unmapped
    function automatic logic is_mapped(input haddr_t a);
        return ((a - sram0_base) < haddr_t'(sram0_words * 4)) ||
               ((a - sram1_base) < haddr_t'(sram1_words * 4));
    endfunction

    function automatic haddr_t rand_addr(input logic region1);
        if (region1) return sram1_base + haddr_t'(($urandom % sram1_words) * 4);
        return sram0_base + haddr_t'(($urandom % sram0_words) * 4);
    endfunction

    // Check the current data phase, done once hready ends it
    task automatic check_data_phase(output logic done);
        haddr_t k;
        k = word_key(pend_addr);
        done = 1'b1;
        case (pend_kind)
            dp_okay: begin
                assert (hready === 1'b1 && hresp === 1'b0)
                    else fail_now($sformatf("no zero-wait OKAY for %h", pend_addr));
                if (pend_write) begin
                    ref_mem[k] = merge_lanes(ref_mem.exists(k) ? ref_mem[k] : '0, pend_wdata,
                                             lane_mask_of(pend_addr, pend_size));
                end else begin
                    assert (hrdata === ref_mem[k])
                        else fail_now($sformatf("read %h returned %h, expected %h",
                                                pend_addr, hrdata, ref_mem[k]));
                end
            end
            dp_error: begin
                if (!pend_stalled) begin
                    assert (hready === 1'b0 && hresp === 1'b1)
                        else fail_now($sformatf("first ERROR cycle wrong for %h", pend_addr));
                    pend_stalled = 1'b1;
                    done = 1'b0;
                end else begin
                    assert (hready === 1'b1 && hresp === 1'b1)
                        else fail_now($sformatf("second ERROR cycle wrong for %h", pend_addr));
                end
            end
            default: begin
                assert (hready === 1'b1 && hresp === 1'b0 && hrdata === '0)
                    else fail_now("idle data phase not a zero-wait OKAY");
            end
        endcase
    endtask

    // One address phase, overlapped with the data phase of the one before
    task automatic bus_xfer(input haddr_t a, input logic w, input hsize_t s, input hdata_t wd,
                            input htrans_t t);
        logic done;
        @(negedge hclk);
        hwdata = pend_wdata;
        haddr  = a;
        hwrite = w;
        hsize  = s;
        htrans = t;
        check_data_phase(done);
        while (!done) begin  // Address held during the stall
            @(negedge hclk);
            check_data_phase(done);
        end
        if (t != trans_nonseq && t != trans_seq) pend_kind = dp_none;
        else if (is_mapped(a)) pend_kind = dp_okay;
        else pend_kind = dp_error;
        pend_write   = w;
        pend_addr    = a;
        pend_size    = s;
        pend_wdata   = wd;
        pend_stalled = 1'b0;
    endtask

    task automatic write_data(input haddr_t a, input hsize_t s, input hdata_t d);
        bus_xfer(a, 1'b1, s, d, trans_nonseq);
    endtask

    task automatic read_word(input haddr_t a);
        bus_xfer(a, 1'b0, size_word, $urandom, trans_nonseq);  // Junk on hwdata
    endtask

    task automatic idle_cycle();
        bus_xfer('0, 1'b0, size_word, '0, trans_idle);
    endtask

    initial begin
        hrstn        = 1'b0;
        haddr        = '0;
        hmastlock    = 1'b0;
        hprot        = 7'h03;  // Privileged data access
        hsize        = size_word;
        htrans       = trans_idle;
        hwdata       = '0;
        hwrite       = 1'b0;
        pend_kind    = dp_none;
        pend_write   = 1'b0;
        pend_addr    = '0;
        pend_size    = size_word;
        pend_wdata   = '0;
        pend_stalled = 1'b0;
        void'($urandom(97));
        repeat (3) @(posedge hclk);
        @(negedge hclk);
        hrstn = 1'b1;
        assert (hready === 1'b1 && hresp === 1'b0)
            else fail_now("hready or hresp wrong after reset");

        // Idle bus, then random words in both SRAMs
        repeat (4) idle_cycle();
        foreach (addr_list[i]) begin
            addr_list[i] = rand_addr(i % 2 == 1);
            write_data(addr_list[i], size_word, $urandom);
        end
        foreach (addr_list[i]) read_word(addr_list[i]);

        // Byte and halfword lanes
        for (int r = 0; r < 2; r++) begin
            haddr_t base;
            base = (r == 1) ? 32'h0001_0040 : 32'h0000_0190;
            write_data(base, size_word, $urandom);
            for (int off = 0; off < 4; off++) begin
                write_data(base + haddr_t'(off), size_byte, $urandom);
                idle_cycle();  // Read from the array, not forwarded
                read_word(base);
            end
            for (int off = 0; off < 4; off += 2) begin
                write_data(base + haddr_t'(off), size_half, $urandom);
                read_word(base);
            end
        end

        // Back-to-back write then read of the same word
        repeat (20) begin
            haddr_t a;
            a = rand_addr($urandom % 2 == 1);
            write_data(a, size_word, $urandom);
            read_word(a);
            write_data(a + haddr_t'($urandom % 4), size_byte, $urandom);
            read_word(a);
        end

        // Unmapped space must not touch the word it would alias
        foreach (alias_addr[i]) write_data(alias_addr[i], size_word, $urandom);
        foreach (bad_addr[i]) begin
            write_data(bad_addr[i], size_word, $urandom);
            read_word(bad_addr[i]);
            read_word(alias_addr[i]);
        end

        // Idle and busy writes leave memory alone
        foreach (addr_list[i]) begin
            bus_xfer(addr_list[i], 1'b1, size_word, $urandom,
                     (i % 2 == 1) ? trans_busy : trans_idle);
            read_word(addr_list[i]);
        end
        idle_cycle();  // Last read data phase
        $display("all tests passed");
        $finish;
    end

endmodule
